// File: include/rsa_config.svh
// array size, word and address widths
// bank layout bases and result credit count
`ifndef RSA_CONFIG_SVH
`define RSA_CONFIG_SVH

// array edge, also the lane count of each bank
`define RSA_N 4
// operand word width, arithmetic wraps at this width
`define RSA_DW 16
// bank address width per lane
`define RSA_AW 4

// A rows in temp bank, B columns in cov bank
`define RSA_AB_BASE 0
// C rows in temp bank
`define RSA_C_BASE 8

// result words the host may take before the first credit return
`define RSA_CREDITS 4

`endif

// File: logic/rsa_pkg.sv
// shared types for the systolic array
// words, addresses, lanes, opcodes and controller states
`include "rsa_config.svh"

package rsa_pkg;

  // one operand or result word
  typedef logic [`RSA_DW-1:0] rsa_word_t;
  // one bank address
  typedef logic [`RSA_AW-1:0] rsa_addr_t;
  // lane or row index
  typedef logic [1:0] rsa_lane_t;

  // stage opcode
  typedef enum logic {
    OP_MUL = 1'b0,  // C = A*B
    OP_ACC = 1'b1   // C = C_old + A*B
  } rsa_op_t;

  // stage controller states
  typedef enum logic [2:0] {
    ST_IDLE, ST_FEED, ST_DRAIN, ST_WB, ST_STREAM
  } rsa_state_t;

endpackage

// File: logic/pe_mac.sv
// multiply-accumulate processing element
// operands forwarded east and south one cycle later
module pe_mac (
  input  logic               clk,
  input  logic               sys_rst,
  input  logic               i_clear,
  input  rsa_pkg::rsa_word_t i_west,
  input  rsa_pkg::rsa_word_t i_north,
  input  logic               i_val,
  output rsa_pkg::rsa_word_t o_east,
  output rsa_pkg::rsa_word_t o_south,
  output logic               o_val,
  output rsa_pkg::rsa_word_t o_acc
);

  // operand pass-through regs
  always_ff @(posedge clk) begin
    o_east  <= i_west;
    o_south <= i_north;
  end

  // valid travels along the row with the west operand
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_val <= 1'b0;
    end else begin
      o_val <= i_val;
    end
  end

  // accumulator
  // product truncated to word width, sum wraps
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_acc <= '0;
    end else if (i_clear) begin
      // new stage starts from zero
      o_acc <= '0;
    end else if (i_val) begin
      o_acc <= o_acc + i_west * i_north;
    end
  end

endmodule

// File: logic/pe_array.sv
// NxN grid of MAC PEs with west/north edge skew
// and a row select on the accumulators
`include "rsa_config.svh"

module pe_array (
  input  logic                            clk,
  input  logic                            sys_rst,
  input  logic                            i_clear,
  input  logic                            i_feed_val,
  input  rsa_pkg::rsa_word_t [`RSA_N-1:0] i_a_col,
  input  rsa_pkg::rsa_word_t [`RSA_N-1:0] i_b_row,
  input  rsa_pkg::rsa_lane_t              i_row_sel,
  output rsa_pkg::rsa_word_t [`RSA_N-1:0] o_c_row
);
  import rsa_pkg::*;

  // edge operands after skew
  rsa_word_t a_edge [`RSA_N];
  rsa_word_t b_edge [`RSA_N];
  logic      v_edge [`RSA_N];

  // PE outputs, indexed [row][col] of the PE that drives them
  rsa_word_t east  [`RSA_N][`RSA_N];
  rsa_word_t south [`RSA_N][`RSA_N];
  logic      val   [`RSA_N][`RSA_N];
  rsa_word_t acc   [`RSA_N][`RSA_N];

  // lane i delayed by i cycles, on both edges
  for (genvar i = 0; i < `RSA_N; i++) begin : g_skew
    rsa_word_t a_dly [i+1];
    rsa_word_t b_dly [i+1];
    logic      v_dly [i+1];

    assign a_dly[0] = i_a_col[i];
    assign b_dly[0] = i_b_row[i];
    assign v_dly[0] = i_feed_val;
    for (genvar d = 1; d <= i; d++) begin : g_stage
      always_ff @(posedge clk) begin
        a_dly[d] <= a_dly[d-1];
        b_dly[d] <= b_dly[d-1];
      end
      always_ff @(posedge clk) begin
        if (sys_rst) begin
          v_dly[d] <= 1'b0;
        end else begin
          v_dly[d] <= v_dly[d-1];
        end
      end
    end
    assign a_edge[i] = a_dly[i];
    assign b_edge[i] = b_dly[i];
    assign v_edge[i] = v_dly[i];
  end

  // grid, A flows east and B flows south
  // both meet at PE(i,j) i+j cycles after the edge
  for (genvar i = 0; i < `RSA_N; i++) begin : g_row
    for (genvar j = 0; j < `RSA_N; j++) begin : g_col
      rsa_word_t west_in;
      rsa_word_t north_in;
      logic      val_in;

      if (j == 0) begin : g_wedge
        assign west_in = a_edge[i];
        assign val_in  = v_edge[i];
      end else begin : g_wlink
        assign west_in = east[i][j-1];
        assign val_in  = val[i][j-1];
      end
      if (i == 0) begin : g_nedge
        assign north_in = b_edge[j];
      end else begin : g_nlink
        assign north_in = south[i-1][j];
      end

      pe_mac u_pe (
        .clk     (clk),
        .sys_rst (sys_rst),
        .i_clear (i_clear),
        .i_west  (west_in),
        .i_north (north_in),
        .i_val   (val_in),
        .o_east  (east[i][j]),
        .o_south (south[i][j]),
        .o_val   (val[i][j]),
        .o_acc   (acc[i][j])
      );
    end
  end

  // one C row for write-back
  for (genvar j = 0; j < `RSA_N; j++) begin : g_out
    assign o_c_row[j] = acc[i_row_sel][j];
  end

endmodule

// File: logic/operand_bank.sv
// N-lane word memory with registered read
// host writes one lane, controller writes a whole row
`include "rsa_config.svh"

module operand_bank (
  input  logic                            clk,
  input  logic                            i_host_we,
  input  rsa_pkg::rsa_lane_t              i_host_lane,
  input  rsa_pkg::rsa_addr_t              i_host_addr,
  input  rsa_pkg::rsa_word_t              i_host_data,
  input  rsa_pkg::rsa_addr_t              i_rd_addr,
  input  logic                            i_wb_we,
  input  rsa_pkg::rsa_addr_t              i_wb_addr,
  input  rsa_pkg::rsa_word_t [`RSA_N-1:0] i_wb_data,
  output rsa_pkg::rsa_word_t [`RSA_N-1:0] o_rd_data
);
  import rsa_pkg::*;

  localparam int DEPTH = 2 ** `RSA_AW;

  for (genvar l = 0; l < `RSA_N; l++) begin : g_lane
    rsa_word_t mem [DEPTH];
    rsa_word_t rd_q;
    logic      host_hit;

    // host only writes while the controller is idle
    assign host_hit = i_host_we && (i_host_lane == rsa_lane_t'(l));

    // single write port, host first
    always_ff @(posedge clk) begin
      if (host_hit) begin
        mem[i_host_addr] <= i_host_data;
      end else if (i_wb_we) begin
        // row write-back, same address on every lane
        mem[i_wb_addr] <= i_wb_data[l];
      end
    end

    // read port
    // old data on a same-address write
    always_ff @(posedge clk) begin
      rd_q <= mem[i_rd_addr];
    end

    assign o_rd_data[l] = rd_q;
  end

endmodule

// File: logic/rsa_ctrl.sv
// stage controller: feed, drain, write-back with optional C add,
// then credit-limited row-major result stream
`include "rsa_config.svh"

module rsa_ctrl (
  input  logic                            clk,
  input  logic                            sys_rst,
  input  logic                            i_stage_val,
  input  rsa_pkg::rsa_op_t                i_stage_op,
  input  logic                            i_res_credit,
  input  rsa_pkg::rsa_word_t [`RSA_N-1:0] i_tb_rd,
  input  rsa_pkg::rsa_word_t [`RSA_N-1:0] i_c_row,
  output logic                            o_stage_rdy,
  output rsa_pkg::rsa_addr_t              o_rd_addr,
  output logic                            o_feed_val,
  output logic                            o_clear,
  output rsa_pkg::rsa_lane_t              o_row_sel,
  output logic                            o_wb_we,
  output rsa_pkg::rsa_addr_t              o_wb_addr,
  output rsa_pkg::rsa_word_t [`RSA_N-1:0] o_wb_data,
  output logic                            o_res_val,
  output rsa_pkg::rsa_word_t              o_res_data
);
  import rsa_pkg::*;

  localparam int NN   = `RSA_N * `RSA_N;
  localparam int IW   = $clog2(NN);
  localparam int CNTW = $clog2(NN + 3 * `RSA_N);
  localparam int CRW  = $clog2(`RSA_CREDITS + 1) + 1;

  // last count of each phase
  localparam logic [CNTW-1:0] FEED_LAST   = CNTW'(`RSA_N - 1);
  localparam logic [CNTW-1:0] DRAIN_LAST  = CNTW'(3 * `RSA_N - 3);
  localparam logic [CNTW-1:0] WB_LAST     = CNTW'(`RSA_N);
  localparam logic [CNTW-1:0] STREAM_LAST = CNTW'(NN - 1);

  rsa_state_t      state;
  rsa_op_t         op_q;
  logic [CNTW-1:0] cnt;
  logic [CRW-1:0]  credit;
  logic            accept;
  // C rows kept for streaming
  rsa_word_t       c_buf [NN];

  assign o_stage_rdy = (state == ST_IDLE);
  assign accept      = o_stage_rdy && i_stage_val;
  // zero the accumulators on acceptance, before the first product
  assign o_clear     = accept;

  // stage sequencing
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state <= ST_IDLE;
      op_q  <= OP_MUL;
      cnt   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            op_q  <= i_stage_op;
            state <= ST_FEED;
          end
        end
        // one column of A and row of B per cycle
        ST_FEED: begin
          cnt <= (cnt == FEED_LAST) ? '0 : cnt + 1'b1;
          if (cnt == FEED_LAST) state <= ST_DRAIN;
        end
        // wait for the last wave to cross the skew
        ST_DRAIN: begin
          cnt <= (cnt == DRAIN_LAST) ? '0 : cnt + 1'b1;
          if (cnt == DRAIN_LAST) state <= ST_WB;
        end
        // N+1 cycles, C read runs one row ahead of the write
        ST_WB: begin
          cnt <= (cnt == WB_LAST) ? '0 : cnt + 1'b1;
          if (cnt == WB_LAST) state <= ST_STREAM;
        end
        // advance only on a sent word
        ST_STREAM: begin
          if (o_res_val) begin
            cnt <= (cnt == STREAM_LAST) ? '0 : cnt + 1'b1;
            if (cnt == STREAM_LAST) state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // bank read address, shared by both banks
  always_comb begin
    case (state)
      ST_FEED: o_rd_addr = rsa_addr_t'(`RSA_AB_BASE + cnt);
      // old C row for the add
      ST_WB:   o_rd_addr = rsa_addr_t'(`RSA_C_BASE + cnt);
      default: o_rd_addr = rsa_addr_t'(`RSA_AB_BASE);
    endcase
  end

  // read data lands a cycle after the address
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_feed_val <= 1'b0;
    end else begin
      o_feed_val <= (state == ST_FEED);
    end
  end

  // write-back of row cnt-1
  assign o_row_sel = rsa_lane_t'(cnt - 1'b1);
  assign o_wb_we   = (state == ST_WB) && (cnt != '0);
  assign o_wb_addr = rsa_addr_t'(`RSA_C_BASE + cnt - 1);

  always_comb begin
    for (int l = 0; l < `RSA_N; l++) begin
      o_wb_data[l] = i_c_row[l];
      if (op_q == OP_ACC) begin
        o_wb_data[l] = i_c_row[l] + i_tb_rd[l];
      end
    end
  end

  // local copy in row-major order
  always_ff @(posedge clk) begin
    if (o_wb_we) begin
      for (int l = 0; l < `RSA_N; l++) begin
        c_buf[int'(o_row_sel) * `RSA_N + l] <= o_wb_data[l];
      end
    end
  end

  // credits, one spent per word and one back per pulse
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      credit <= CRW'(`RSA_CREDITS);
    end else begin
      credit <= credit + CRW'(i_res_credit) - CRW'(o_res_val);
    end
  end

  // word held until a credit frees it
  assign o_res_val  = (state == ST_STREAM) && (credit != '0);
  assign o_res_data = c_buf[cnt[IW-1:0]];

endmodule

// File: logic/rsa_top.sv
// systolic array top: temp and cov banks,
// PE array and stage controller
`include "rsa_config.svh"

module rsa_top (
  input  logic               clk,
  input  logic               sys_rst,
  // host bank writes
  input  logic               i_host_wr_en,
  input  logic               i_host_wr_bank,
  input  rsa_pkg::rsa_lane_t i_host_wr_lane,
  input  rsa_pkg::rsa_addr_t i_host_wr_addr,
  input  rsa_pkg::rsa_word_t i_host_wr_data,
  // stage start
  input  logic               i_stage_val,
  input  rsa_pkg::rsa_op_t   i_stage_op,
  output logic               o_stage_rdy,
  // result stream
  output logic               o_res_val,
  output rsa_pkg::rsa_word_t o_res_data,
  input  logic               i_res_credit
);
  import rsa_pkg::*;

  // bank read side
  rsa_addr_t                rd_addr;
  rsa_word_t [`RSA_N-1:0]   tb_rd;
  rsa_word_t [`RSA_N-1:0]   cb_rd;
  // array control and result row
  logic                     feed_val;
  logic                     clear;
  rsa_lane_t                row_sel;
  rsa_word_t [`RSA_N-1:0]   c_row;
  // temp bank write-back
  logic                     wb_we;
  rsa_addr_t                wb_addr;
  rsa_word_t [`RSA_N-1:0]   wb_data;

  // A rows and C rows, bank select 0
  operand_bank u_temp_bank (
    .clk         (clk),
    .i_host_we   (i_host_wr_en && !i_host_wr_bank),
    .i_host_lane (i_host_wr_lane),
    .i_host_addr (i_host_wr_addr),
    .i_host_data (i_host_wr_data),
    .i_rd_addr   (rd_addr),
    .i_wb_we     (wb_we),
    .i_wb_addr   (wb_addr),
    .i_wb_data   (wb_data),
    .o_rd_data   (tb_rd)
  );

  // B columns, bank select 1, never written back
  operand_bank u_cov_bank (
    .clk         (clk),
    .i_host_we   (i_host_wr_en && i_host_wr_bank),
    .i_host_lane (i_host_wr_lane),
    .i_host_addr (i_host_wr_addr),
    .i_host_data (i_host_wr_data),
    .i_rd_addr   (rd_addr),
    .i_wb_we     (1'b0),
    .i_wb_addr   ('0),
    .i_wb_data   ('0),
    .o_rd_data   (cb_rd)
  );

  // temp lanes are A rows at the west edge, cov lanes B columns at the north
  pe_array u_pe_array (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .i_clear    (clear),
    .i_feed_val (feed_val),
    .i_a_col    (tb_rd),
    .i_b_row    (cb_rd),
    .i_row_sel  (row_sel),
    .o_c_row    (c_row)
  );

  rsa_ctrl u_rsa_ctrl (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .i_stage_val  (i_stage_val),
    .i_stage_op   (i_stage_op),
    .i_res_credit (i_res_credit),
    .i_tb_rd      (tb_rd),
    .i_c_row      (c_row),
    .o_stage_rdy  (o_stage_rdy),
    .o_rd_addr    (rd_addr),
    .o_feed_val   (feed_val),
    .o_clear      (clear),
    .o_row_sel    (row_sel),
    .o_wb_we      (wb_we),
    .o_wb_addr    (wb_addr),
    .o_wb_data    (wb_data),
    .o_res_val    (o_res_val),
    .o_res_data   (o_res_data)
  );

endmodule

// File: dv/rsa_assertions.sv
// protocol checks bound to the systolic array top
// credit accounting, reset values and the stage ready window
`include "rsa_config.svh"

module rsa_assertions (
  input logic clk,
  input logic sys_rst,
  input logic i_stage_val,
  input logic i_stage_rdy,
  input logic i_res_val,
  input logic i_res_credit
);

  localparam int STAGE_WORDS = `RSA_N * `RSA_N;

  // failure counts, read by the testbench
  int   err_credit = 0;
  int   err_reset  = 0;
  int   err_stage  = 0;
  // credit pulses and words seen since reset
  int   returned;
  int   received;
  // stage in flight, words sent in it
  logic busy;
  int   stage_words;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      returned <= 0;
      received <= 0;
    end else begin
      if (i_res_credit) returned <= returned + 1;
      if (i_res_val) received <= received + 1;
    end
  end

  // busy from acceptance until the last word leaves
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      busy        <= 1'b0;
      stage_words <= 0;
    end else begin
      if (i_stage_val && i_stage_rdy) busy <= 1'b1;
      if (i_res_val) begin
        if (stage_words == STAGE_WORDS - 1) begin
          stage_words <= 0;
          busy        <= 1'b0;
        end else begin
          stage_words <= stage_words + 1;
        end
      end
    end
  end

  // no word while the DUT's credit count is zero
  a_credit: assert property (@(posedge clk) disable iff (sys_rst)
    !(i_res_val && (returned + `RSA_CREDITS == received)))
    else begin
      err_credit = err_credit + 1;
      $error("result word sent with no credit left");
    end

  a_reset: assert property (@(posedge clk) sys_rst |=> (i_stage_rdy && !i_res_val))
    else begin
      err_reset = err_reset + 1;
      $error("stage ready or result valid wrong after reset");
    end

  // ready low exactly while a stage is in flight
  a_ready: assert property (@(posedge clk) disable iff (sys_rst) i_stage_rdy == !busy)
    else begin
      err_stage = err_stage + 1;
      $error("stage ready does not match the stage in flight");
    end

endmodule

bind rsa_top rsa_assertions u_assertions (
  .clk          (clk),
  .sys_rst      (sys_rst),
  .i_stage_val  (i_stage_val),
  .i_stage_rdy  (o_stage_rdy),
  .i_res_val    (o_res_val),
  .i_res_credit (i_res_credit)
);

// File: dv/rsa_tb.sv
// testbench for the systolic array top
// random operands, reference model of C, stream checks, credit throttling
`include "rsa_config.svh"

module rsa_tb;
  import rsa_pkg::*;

  localparam logic [31:0] SEED       = 32'h0e38_a32b;
  localparam int          WAIT_LIMIT = 400;
  localparam int          NN         = `RSA_N * `RSA_N;

  logic      clk = 1'b0;
  logic      sys_rst;
  logic      i_host_wr_en;
  logic      i_host_wr_bank;
  rsa_lane_t i_host_wr_lane;
  rsa_addr_t i_host_wr_addr;
  rsa_word_t i_host_wr_data;
  logic      i_stage_val;
  rsa_op_t   i_stage_op;
  logic      o_stage_rdy;
  logic      o_res_val;
  rsa_word_t o_res_data;
  logic      i_res_credit = 1'b0;

  // operands and the temp-bank C region as the model keeps it
  rsa_word_t   mat_a   [`RSA_N][`RSA_N];
  rsa_word_t   mat_b   [`RSA_N][`RSA_N];
  rsa_word_t   c_model [`RSA_N][`RSA_N];
  rsa_word_t   exp_q   [$];
  string       test_name   = "";
  int          words_got   = 0;
  logic [31:0] rng         = SEED;
  logic [31:0] bp_rng      = SEED;
  logic        throttle    = 1'b0;
  logic        word_seen   = 1'b0;
  int          owed        = 0;
  int          hold_cycles = 0;

  rsa_top i_dut (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_host_wr_en   (i_host_wr_en),
    .i_host_wr_bank (i_host_wr_bank),
    .i_host_wr_lane (i_host_wr_lane),
    .i_host_wr_addr (i_host_wr_addr),
    .i_host_wr_data (i_host_wr_data),
    .i_stage_val    (i_stage_val),
    .i_stage_op     (i_stage_op),
    .o_stage_rdy    (o_stage_rdy),
    .o_res_val      (o_res_val),
    .o_res_data     (o_res_data),
    .i_res_credit   (i_res_credit)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int assert_errors();
    return i_dut.u_assertions.err_credit + i_dut.u_assertions.err_reset
         + i_dut.u_assertions.err_stage;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  // new random A and B
  task automatic fill_random(input bit identity_a);
    for (int i = 0; i < `RSA_N; i++) begin
      for (int k = 0; k < `RSA_N; k++) begin
        rng = xorshift32(rng);
        mat_a[i][k] = identity_a ? rsa_word_t'(i == k) : rng[15:0];
        mat_b[i][k] = rng[31:16];
      end
    end
  endtask

  // C = A*B, plus the old C for accumulate, all mod 2^16
  task automatic push_expected(input rsa_op_t op);
    rsa_word_t sum;
    for (int i = 0; i < `RSA_N; i++) begin
      for (int j = 0; j < `RSA_N; j++) begin
        sum = (op == OP_ACC) ? c_model[i][j] : '0;
        for (int k = 0; k < `RSA_N; k++) begin
          sum = sum + mat_a[i][k] * mat_b[k][j];
        end
        c_model[i][j] = sum;
        exp_q.push_back(sum);
      end
    end
  endtask

  task automatic wait_ready(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!o_stage_rdy) begin
      if (cycles >= WAIT_LIMIT) fail_run($sformatf("timeout waiting for ready before %s", what));
      cycles++;
      @(negedge clk);
    end
  endtask

  // wait until only left words are still expected
  task automatic wait_words(input int left);
    int idle;
    int last;
    idle = 0;
    last = exp_q.size();
    while (exp_q.size() > left) begin
      @(posedge clk);
      if (exp_q.size() != last) begin
        idle = 0;
        last = exp_q.size();
      end else begin
        idle++;
      end
      if (idle > WAIT_LIMIT) fail_run($sformatf("timeout in %s waiting for results", test_name));
    end
  endtask

  task automatic host_write(input logic bank, input int lane, input int addr,
                            input rsa_word_t data);
    @(posedge clk);
    i_host_wr_en   <= 1'b1;
    i_host_wr_bank <= bank;
    i_host_wr_lane <= rsa_lane_t'(lane);
    i_host_wr_addr <= rsa_addr_t'(addr);
    i_host_wr_data <= data;
  endtask

  // A rows to the temp bank, B columns to the cov bank
  task automatic load_operands();
    wait_ready("operand load");
    for (int i = 0; i < `RSA_N; i++) begin
      for (int k = 0; k < `RSA_N; k++) begin
        host_write(1'b0, i, `RSA_AB_BASE + k, mat_a[i][k]);
        host_write(1'b1, i, `RSA_AB_BASE + k, mat_b[k][i]);
      end
    end
    @(posedge clk);
    i_host_wr_en <= 1'b0;
  endtask

  // chain keeps valid high so the next stage waits on ready
  task automatic start_stage(input rsa_op_t op, input bit chain, input rsa_op_t next_op);
    wait_ready("stage start");
    @(posedge clk);
    i_stage_val <= 1'b1;
    i_stage_op  <= op;
    @(negedge clk);
    assert (o_stage_rdy) else fail_run("ready dropped before the stage was accepted");
    // acceptance edge
    @(posedge clk);
    if (chain) i_stage_op <= next_op;
    else i_stage_val <= 1'b0;
  endtask

  task automatic run_stage(input rsa_op_t op);
    push_expected(op);
    start_stage(op, 1'b0, OP_MUL);
    wait_words(0);
  endtask

  // a word seen here is taken at the next rising edge
  always @(negedge clk) begin : check_words
    rsa_word_t want;
    word_seen = 1'b0;
    if (!sys_rst && o_res_val) begin
      word_seen = 1'b1;
      if (exp_q.size() == 0) begin
        fail_run("result word arrived with none expected");
      end else begin
        want = exp_q.pop_front();
        assert (o_res_data == want)
          else fail_run($sformatf("mismatch %s word %0d: expected %h actual %h",
                                  test_name, words_got % NN, want, o_res_data));
        words_got++;
      end
    end
  end

  // bound assertion failures end the run too
  always @(negedge clk) begin
    if (assert_errors() != 0) fail_run("a bound protocol assertion failed");
  end

  // credit return, one pulse per taken word
  // throttled mode holds credits back for random stretches
  always @(posedge clk) begin
    if (sys_rst) begin
      owed = 0;
      hold_cycles = 0;
      i_res_credit <= 1'b0;
    end else begin
      if (word_seen) owed = owed + 1;
      if (hold_cycles > 0) begin
        hold_cycles = hold_cycles - 1;
      end else if (throttle) begin
        bp_rng = xorshift32(bp_rng);
        if (bp_rng[1:0] == 2'b00) hold_cycles = 4 + int'(bp_rng[7:4]);
      end
      if (owed > 0 && hold_cycles == 0) begin
        i_res_credit <= 1'b1;
        owed = owed - 1;
      end else begin
        i_res_credit <= 1'b0;
      end
    end
  end

  initial begin : stimulus
    sys_rst        = 1'b1;
    i_host_wr_en   = 1'b0;
    i_host_wr_bank = 1'b0;
    i_host_wr_lane = '0;
    i_host_wr_addr = '0;
    i_host_wr_data = '0;
    i_stage_val    = 1'b0;
    i_stage_op     = OP_MUL;
    repeat (3) @(posedge clk);
    sys_rst <= 1'b0;

    test_name = "reset";
    @(negedge clk);
    assert (o_stage_rdy && !o_res_val) else fail_run("ready or result valid wrong after reset");

    test_name = "mul_random";
    fill_random(1'b0);
    load_operands();
    run_stage(OP_MUL);

    // C region left by the previous stage is the addend
    test_name = "acc_after_mul";
    fill_random(1'b0);
    load_operands();
    run_stage(OP_ACC);

    test_name = "back_pressure";
    throttle = 1'b1;
    fill_random(1'b0);
    load_operands();
    run_stage(OP_MUL);
    run_stage(OP_ACC);
    throttle = 1'b0;

    // result equals B, every skew lane used
    test_name = "identity_a";
    fill_random(1'b1);
    load_operands();
    run_stage(OP_MUL);

    // second stage pending on valid while the first one runs
    test_name = "stage_handshake";
    fill_random(1'b0);
    load_operands();
    push_expected(OP_MUL);
    push_expected(OP_ACC);
    start_stage(OP_MUL, 1'b1, OP_ACC);
    wait_words(NN);
    wait_ready("chained stage");
    assert (exp_q.size() == NN) else fail_run("ready rose before the first stage finished");
    @(posedge clk);
    i_stage_val <= 1'b0;
    wait_words(0);
    wait_ready("end of run");

    if (assert_errors() == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      fail_run("a bound protocol assertion failed");
    end
  end

endmodule

// File: all.f
+incdir+include
logic/rsa_pkg.sv
logic/pe_mac.sv
logic/pe_array.sv
logic/operand_bank.sv
logic/rsa_ctrl.sv
logic/rsa_top.sv
dv/rsa_assertions.sv
dv/rsa_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the systolic array testbench with Verilator, run it and check the log.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module rsa_tb -Mdir "$build_dir" -o rsa_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$build_dir/rsa_sim" +verilator+error+limit+100 > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "PASS: all tests" "$log_file"; then
  exit 0
fi
echo "pass line not found in $log_file"
exit 1
